// ==== Bender.yml ====
package:
  name: rv_decoder

sources:
  # packages first, then the decoders and the top level
  - files:
      - design/rv_isa_pkg.sv
      - design/decode_ctrl_pkg.sv
      - design/alu_decoder.sv
      - design/mem_decoder.sv
      - design/decode_stage.sv
      - design/rv_decoder.sv

  - target: test
    files:
      - testbench/rv_decoder_tb.sv

// ==== design/alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decoder #(
    parameter int XLEN = 64
) (
    input  wire rv_isa_pkg::inst_t      inst,
    output logic                        alu_hit,
    output decode_ctrl_pkg::alu_op_e    alu_op,
    output decode_ctrl_pkg::alu_src_e   alu_src,
    output decode_ctrl_pkg::imm_sel_e   imm_sel,
    output logic                        word_op,
    output logic                        uses_rs1,
    output logic                        uses_rs2,
    output logic                        writes_rd,
    output logic                        branch,
    output logic                        jump,
    output logic                        jalr
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam bit rv64 = (XLEN == 64);

    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;
    funct7_t shift_f7;

    assign opcode = opcode_e'(inst[opcode_lsb +: opcode_width]);
    assign funct3 = inst[funct3_lsb +: funct3_width];
    assign funct7 = inst[funct7_lsb +: funct7_width];
    assign shift_f7 = rv64 ? {funct7[6:1], 1'b0} : funct7;   // bit 25 is shamt[5] on rv64

    always_comb begin
        alu_hit   = 1'b0;
        alu_op    = alu_add;
        alu_src   = src_reg;
        imm_sel   = imm_i;
        word_op   = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        case (opcode)
            opc_op: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                case (funct3)
                    f3_add: begin
                        alu_hit = (funct7 == funct7_base) || (funct7 == funct7_alt);
                        alu_op  = (funct7 == funct7_alt) ? alu_sub : alu_add;
                    end
                    f3_sltu: begin
                        alu_hit = (funct7 == funct7_base);
                        alu_op  = alu_sltu;
                    end
                    f3_or: begin
                        alu_hit = (funct7 == funct7_base) || (funct7 == funct7_muldiv);
                        alu_op  = (funct7 == funct7_muldiv) ? alu_rem : alu_or;
                    end
                    f3_and: begin
                        alu_hit = (funct7 == funct7_base) || (funct7 == funct7_muldiv);
                        alu_op  = (funct7 == funct7_muldiv) ? alu_remu : alu_and;
                    end
                    default: alu_hit = 1'b0;
                endcase
            end
            opc_op_imm: begin
                alu_src   = src_imm;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                alu_hit   = 1'b1;
                case (funct3)
                    f3_add:  alu_op = alu_add;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_and:  alu_op = alu_and;
                    f3_sll: begin
                        imm_sel = imm_shamt;
                        alu_op  = alu_sll;
                        alu_hit = (shift_f7 == funct7_base);
                    end
                    f3_srl: begin
                        imm_sel = imm_shamt;
                        alu_op  = (shift_f7 == funct7_alt) ? alu_sra : alu_srl;
                        alu_hit = (shift_f7 == funct7_base) || (shift_f7 == funct7_alt);
                    end
                    default: alu_hit = 1'b0;
                endcase
            end
            opc_op_32: begin
                word_op   = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                case (funct3)
                    f3_add: begin   // addw, mulw
                        alu_hit = rv64 && ((funct7 == funct7_base) || (funct7 == funct7_muldiv));
                        alu_op  = (funct7 == funct7_muldiv) ? alu_mul : alu_add;
                    end
                    f3_sll: begin
                        alu_hit = rv64 && (funct7 == funct7_base);
                        alu_op  = alu_sll;
                    end
                    f3_div: begin
                        alu_hit = rv64 && (funct7 == funct7_muldiv);
                        alu_op  = alu_div;
                    end
                    f3_rem: begin
                        alu_hit = rv64 && (funct7 == funct7_muldiv);
                        alu_op  = alu_rem;
                    end
                    default: alu_hit = 1'b0;
                endcase
            end
            opc_op_imm_32: begin   // addiw only
                word_op   = 1'b1;
                alu_src   = src_imm;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                alu_hit   = rv64 && (funct3 == f3_add);
            end
            opc_lui: begin
                alu_src   = src_imm;
                imm_sel   = imm_u;
                writes_rd = 1'b1;
                alu_hit   = 1'b1;
            end
            opc_auipc: begin
                alu_src   = src_imm_pc;
                imm_sel   = imm_u;
                writes_rd = 1'b1;
                alu_hit   = 1'b1;
            end
            opc_jal: begin
                alu_src   = src_four_pc;
                imm_sel   = imm_j;
                writes_rd = 1'b1;
                jump      = 1'b1;
                alu_hit   = 1'b1;
            end
            opc_jalr: begin
                alu_src   = src_four_pc;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                jump      = 1'b1;
                jalr      = 1'b1;
                alu_hit   = (funct3 == f3_jalr);
            end
            opc_branch: begin
                imm_sel  = imm_b;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                branch   = 1'b1;
                alu_hit  = 1'b1;
                case (funct3)
                    f3_beq:  alu_op = alu_cmp_eq;
                    f3_bne:  alu_op = alu_cmp_ne;
                    f3_bge:  alu_op = alu_cmp_ge;
                    f3_bltu: alu_op = alu_cmp_ltu;
                    default: alu_hit = 1'b0;   // bgeu and the rest
                endcase
            end
            default: alu_hit = 1'b0;
        endcase
        if (!alu_hit) begin   // a miss reads and writes nothing
            word_op   = 1'b0;
            uses_rs1  = 1'b0;
            uses_rs2  = 1'b0;
            writes_rd = 1'b0;
            branch    = 1'b0;
            jump      = 1'b0;
            jalr      = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_ctrl_pkg.sv ====
`default_nettype none

package decode_ctrl_pkg;

    typedef enum logic [4:0] {
        alu_add     = 5'd0,
        alu_sub     = 5'd1,
        alu_and     = 5'd2,
        alu_or      = 5'd3,
        alu_xor     = 5'd4,
        alu_sltu    = 5'd5,
        alu_sll     = 5'd6,
        alu_srl     = 5'd7,
        alu_sra     = 5'd8,
        alu_mul     = 5'd9,
        alu_div     = 5'd10,
        alu_rem     = 5'd11,
        alu_remu    = 5'd12,
        alu_cmp_eq  = 5'd13,   // branch compares
        alu_cmp_ne  = 5'd14,
        alu_cmp_ge  = 5'd15,
        alu_cmp_ltu = 5'd16
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg     = 2'd0,
        src_imm     = 2'd1,
        src_imm_pc  = 2'd2,
        src_four_pc = 2'd3   // link value pc + 4
    } alu_src_e;

    typedef enum logic [2:0] {
        imm_i     = 3'd0,
        imm_s     = 3'd1,
        imm_b     = 3'd2,
        imm_u     = 3'd3,
        imm_j     = 3'd4,
        imm_shamt = 3'd5
    } imm_sel_e;

    typedef enum logic [2:0] {
        load_none          = 3'd0,
        load_word_signed   = 3'd1,
        load_double        = 3'd2,
        load_byte_unsigned = 3'd3
    } load_kind_e;

    typedef logic [7:0] store_mask_t;   // one bit per byte lane

    parameter store_mask_t mask_none   = 8'h00;
    parameter store_mask_t mask_byte   = 8'h01;
    parameter store_mask_t mask_half   = 8'h03;
    parameter store_mask_t mask_word   = 8'h0f;
    parameter store_mask_t mask_double = 8'hff;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int XLEN = 64
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 inst_valid,
    input  wire rv_isa_pkg::inst_t              inst,
    input  wire                                 alu_hit,
    input  wire decode_ctrl_pkg::alu_op_e       alu_op_d,
    input  wire decode_ctrl_pkg::alu_src_e      alu_src_d,
    input  wire decode_ctrl_pkg::imm_sel_e      imm_sel_d,
    input  wire                                 word_op_d,
    input  wire                                 uses_rs1,
    input  wire                                 uses_rs2,
    input  wire                                 writes_rd,
    input  wire                                 branch_d,
    input  wire                                 jump_d,
    input  wire                                 jalr_d,
    input  wire                                 mem_hit,
    input  wire decode_ctrl_pkg::load_kind_e    load_kind_d,
    input  wire decode_ctrl_pkg::store_mask_t   store_mask_d,
    input  wire [XLEN-1:0]                      mem_offset_d,
    output logic                                dec_valid,
    output logic                                reg_wen,
    output logic                                branch,
    output logic                                jump,
    output logic                                jalr,
    output logic                                word_op,
    output logic                                illegal,
    output logic                                ebreak,
    output rv_isa_pkg::reg_addr_t               rs1_addr,
    output rv_isa_pkg::reg_addr_t               rs2_addr,
    output rv_isa_pkg::reg_addr_t               rd_addr,
    output decode_ctrl_pkg::alu_op_e            alu_op,
    output decode_ctrl_pkg::alu_src_e           alu_src,
    output decode_ctrl_pkg::imm_sel_e           imm_sel,
    output decode_ctrl_pkg::load_kind_e         load_kind,
    output decode_ctrl_pkg::store_mask_t        store_mask,
    output logic [XLEN-1:0]                     mem_offset
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    logic      is_ebreak;
    logic      is_illegal;
    logic      is_load;
    logic      is_store;
    logic      live;
    reg_addr_t rs1_field;
    reg_addr_t rs2_field;
    reg_addr_t rd_field;

    assign is_ebreak  = (inst == ebreak_word);
    assign is_illegal = !alu_hit && !mem_hit && !is_ebreak;
    assign live       = inst_valid && !is_illegal && !is_ebreak;   // allowed to act
    assign is_load    = mem_hit && (load_kind_d != load_none);
    assign is_store   = mem_hit && !is_load;

    assign rs1_field = inst[rs1_lsb +: reg_addr_width];
    assign rs2_field = inst[rs2_lsb +: reg_addr_width];
    assign rd_field  = inst[rd_lsb +: reg_addr_width];

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid  <= 1'b0;
            reg_wen    <= 1'b0;
            branch     <= 1'b0;
            jump       <= 1'b0;
            jalr       <= 1'b0;
            word_op    <= 1'b0;
            illegal    <= 1'b0;
            ebreak     <= 1'b0;
            store_mask <= mask_none;
        end else begin
            dec_valid  <= inst_valid;   // bubble drops everything below
            reg_wen    <= live && (writes_rd || is_load);
            branch     <= live && branch_d;
            jump       <= live && jump_d;
            jalr       <= live && jalr_d;
            word_op    <= live && word_op_d;
            illegal    <= inst_valid && is_illegal;
            ebreak     <= inst_valid && is_ebreak;
            store_mask <= live ? store_mask_d : mask_none;
        end
    end

    // payload, only meaningful while dec_valid
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            rs1_addr   <= (uses_rs1 || mem_hit) ? rs1_field : '0;
            rs2_addr   <= (uses_rs2 || is_store) ? rs2_field : '0;
            rd_addr    <= (writes_rd || is_load) ? rd_field : '0;
            alu_op     <= mem_hit ? alu_add : alu_op_d;   // address add
            alu_src    <= mem_hit ? src_imm : alu_src_d;
            imm_sel    <= mem_hit ? (is_store ? imm_s : imm_i) : imm_sel_d;
            load_kind  <= load_kind_d;
            mem_offset <= mem_offset_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_decoder #(
    parameter int XLEN = 64
) (
    input  wire rv_isa_pkg::inst_t          inst,
    output logic                            mem_hit,
    output decode_ctrl_pkg::load_kind_e     load_kind,
    output decode_ctrl_pkg::store_mask_t    store_mask,
    output logic [XLEN-1:0]                 mem_offset
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam bit rv64 = (XLEN == 64);

    opcode_e         opcode;
    funct3_t         funct3;
    logic [11:0]     imm_i_raw;
    logic [11:0]     imm_s_raw;
    logic [XLEN-1:0] imm_i_ext;
    logic [XLEN-1:0] imm_s_ext;

    assign opcode = opcode_e'(inst[opcode_lsb +: opcode_width]);
    assign funct3 = inst[funct3_lsb +: funct3_width];

    assign imm_i_raw = inst[31:20];
    assign imm_s_raw = {inst[31:25], inst[11:7]};   // split around rs2/rs1
    assign imm_i_ext = {{(XLEN-12){imm_i_raw[11]}}, imm_i_raw};
    assign imm_s_ext = {{(XLEN-12){imm_s_raw[11]}}, imm_s_raw};

    always_comb begin
        mem_hit    = 1'b0;
        load_kind  = load_none;
        store_mask = mask_none;
        mem_offset = '0;
        case (opcode)
            opc_load: begin
                case (funct3)
                    f3_word:   load_kind = load_word_signed;
                    f3_double: load_kind = rv64 ? load_double : load_none;
                    f3_byte_u: load_kind = load_byte_unsigned;
                    default:   load_kind = load_none;
                endcase
                mem_hit    = (load_kind != load_none);
                mem_offset = mem_hit ? imm_i_ext : '0;
            end
            opc_store: begin
                case (funct3)
                    f3_byte:   store_mask = mask_byte;
                    f3_half:   store_mask = mask_half;
                    f3_word:   store_mask = mask_word;
                    f3_double: store_mask = rv64 ? mask_double : mask_none;
                    default:   store_mask = mask_none;
                endcase
                mem_hit    = (store_mask != mask_none);
                mem_offset = mem_hit ? imm_s_ext : '0;
            end
            default: mem_hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
    parameter int XLEN = 64
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             inst_valid,
    input  wire rv_isa_pkg::inst_t          inst,
    output logic                            dec_valid,
    output logic                            reg_wen,
    output logic                            branch,
    output logic                            jump,
    output logic                            jalr,
    output logic                            word_op,
    output logic                            illegal,
    output logic                            ebreak,
    output rv_isa_pkg::reg_addr_t           rs1_addr,
    output rv_isa_pkg::reg_addr_t           rs2_addr,
    output rv_isa_pkg::reg_addr_t           rd_addr,
    output decode_ctrl_pkg::alu_op_e        alu_op,
    output decode_ctrl_pkg::alu_src_e       alu_src,
    output decode_ctrl_pkg::imm_sel_e       imm_sel,
    output decode_ctrl_pkg::load_kind_e     load_kind,
    output decode_ctrl_pkg::store_mask_t    store_mask,
    output logic [XLEN-1:0]                 mem_offset
);
    import decode_ctrl_pkg::*;

    logic            alu_hit;
    alu_op_e         alu_op_d;
    alu_src_e        alu_src_d;
    imm_sel_e        imm_sel_d;
    logic            word_op_d;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            writes_rd;
    logic            branch_d;
    logic            jump_d;
    logic            jalr_d;
    logic            mem_hit;
    load_kind_e      load_kind_d;
    store_mask_t     store_mask_d;
    logic [XLEN-1:0] mem_offset_d;

    alu_decoder #(.XLEN(XLEN)) u_alu_decoder (
        .inst      (inst),
        .alu_hit   (alu_hit),
        .alu_op    (alu_op_d),
        .alu_src   (alu_src_d),
        .imm_sel   (imm_sel_d),
        .word_op   (word_op_d),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd),
        .branch    (branch_d),
        .jump      (jump_d),
        .jalr      (jalr_d)
    );

    mem_decoder #(.XLEN(XLEN)) u_mem_decoder (
        .inst       (inst),
        .mem_hit    (mem_hit),
        .load_kind  (load_kind_d),
        .store_mask (store_mask_d),
        .mem_offset (mem_offset_d)
    );

    decode_stage #(.XLEN(XLEN)) u_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .alu_hit      (alu_hit),
        .alu_op_d     (alu_op_d),
        .alu_src_d    (alu_src_d),
        .imm_sel_d    (imm_sel_d),
        .word_op_d    (word_op_d),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .writes_rd    (writes_rd),
        .branch_d     (branch_d),
        .jump_d       (jump_d),
        .jalr_d       (jalr_d),
        .mem_hit      (mem_hit),
        .load_kind_d  (load_kind_d),
        .store_mask_d (store_mask_d),
        .mem_offset_d (mem_offset_d),
        .dec_valid    (dec_valid),
        .reg_wen      (reg_wen),
        .branch       (branch),
        .jump         (jump),
        .jalr         (jalr),
        .word_op      (word_op),
        .illegal      (illegal),
        .ebreak       (ebreak),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .imm_sel      (imm_sel),
        .load_kind    (load_kind),
        .store_mask   (store_mask),
        .mem_offset   (mem_offset)
    );

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    parameter int inst_width     = 32;
    parameter int reg_addr_width = 5;
    parameter int opcode_width   = 7;
    parameter int funct3_width   = 3;
    parameter int funct7_width   = 7;

    // lsb of each field inside the instruction word
    parameter int opcode_lsb = 0;
    parameter int rd_lsb     = 7;
    parameter int funct3_lsb = 12;
    parameter int rs1_lsb    = 15;
    parameter int rs2_lsb    = 20;
    parameter int funct7_lsb = 25;

    typedef logic [inst_width-1:0]     inst_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [funct3_width-1:0]   funct3_t;
    typedef logic [funct7_width-1:0]   funct7_t;

    typedef enum logic [opcode_width-1:0] {
        opc_op        = 7'b0110011,
        opc_op_imm    = 7'b0010011,
        opc_op_32     = 7'b0111011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_branch    = 7'b1100011
    } opcode_e;

    parameter funct3_t f3_add    = 3'b000;
    parameter funct3_t f3_sll    = 3'b001;
    parameter funct3_t f3_sltu   = 3'b011;
    parameter funct3_t f3_xor    = 3'b100;
    parameter funct3_t f3_srl    = 3'b101;
    parameter funct3_t f3_or     = 3'b110;
    parameter funct3_t f3_and    = 3'b111;
    parameter funct3_t f3_div    = 3'b100;   // m extension, word form
    parameter funct3_t f3_rem    = 3'b110;
    parameter funct3_t f3_jalr   = 3'b000;
    parameter funct3_t f3_byte   = 3'b000;
    parameter funct3_t f3_half   = 3'b001;
    parameter funct3_t f3_word   = 3'b010;
    parameter funct3_t f3_double = 3'b011;
    parameter funct3_t f3_byte_u = 3'b100;
    parameter funct3_t f3_beq    = 3'b000;
    parameter funct3_t f3_bne    = 3'b001;
    parameter funct3_t f3_bge    = 3'b101;
    parameter funct3_t f3_bltu   = 3'b110;

    parameter funct7_t funct7_base   = 7'b0000000;
    parameter funct7_t funct7_alt    = 7'b0100000;   // sub, sra
    parameter funct7_t funct7_muldiv = 7'b0000001;

    parameter inst_t ebreak_word = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== rv_decoder.f ====
design/rv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/alu_decoder.sv
design/mem_decoder.sv
design/decode_stage.sv
design/rv_decoder.sv
testbench/rv_decoder_tb.sv

// ==== testbench/rv_decoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_tb;
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    typedef struct {
        bit          bubble;   // idle cycle before this row
        inst_t       tmpl;
        logic [2:0]  regs;     // rd, rs1, rs2 fields present and read
        alu_op_e     op;
        alu_src_e    src;
        imm_sel_e    imm;
        logic        wen;
        logic        word;
        logic        br;
        logic        jmp;
        logic        jr;
        logic        ill;
        logic        ebk;
        load_kind_e  lk;
        store_mask_t mask;
        logic [63:0] off;
    } row_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        inst_valid = 1'b1;   // live during reset
    inst_t       inst = 32'h000000E7;   // jalr x1 held off by reset

    logic        dec_valid;
    logic        reg_wen;
    logic        branch;
    logic        jump;
    logic        jalr;
    logic        word_op;
    logic        illegal;
    logic        ebreak;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    reg_addr_t   rd_addr;
    alu_op_e     alu_op;
    alu_src_e    alu_src;
    imm_sel_e    imm_sel;
    load_kind_e  load_kind;
    store_mask_t store_mask;
    logic [63:0] mem_offset;

    row_t        rows[$];
    reg_addr_t   rd_f[$];
    reg_addr_t   rs1_f[$];
    reg_addr_t   rs2_f[$];
    logic [15:0] lfsr = 16'd51;
    int          checks = 0;
    int          errors = 0;
    int          checked_row = -1;
    bit          timed_out = 1'b0;

    rv_decoder #(.XLEN(64)) UUT (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .reg_wen    (reg_wen),
        .branch     (branch),
        .jump       (jump),
        .jalr       (jalr),
        .word_op    (word_op),
        .illegal    (illegal),
        .ebreak     (ebreak),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd_addr    (rd_addr),
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .imm_sel    (imm_sel),
        .load_kind  (load_kind),
        .store_mask (store_mask),
        .mem_offset (mem_offset)
    );

    always #5 clk = ~clk;

    initial begin
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        inst_valid <= 1'b0;
        inst <= '0;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 16'hB400;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    task random_field(output reg_addr_t f);
        int b;
        f = '0;
        for (b = 0; b < 5; b++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            f = {f[3:0], lfsr[0]};
        end
    endtask

    task push_row(input row_t r);
        reg_addr_t f;
        rows.push_back(r);
        random_field(f);
        rd_f.push_back(f);
        random_field(f);
        rs1_f.push_back(f);
        random_field(f);
        rs2_f.push_back(f);
    endtask

    // flags are wen, word, br, jmp, jr, ill, ebk
    task alu_row(input bit bub, input inst_t tmpl, input logic [2:0] regs, input alu_op_e op,
                 input alu_src_e src, input imm_sel_e imm, input logic [6:0] flags);
        row_t r;
        r.bubble = bub;
        r.tmpl   = tmpl;
        r.regs   = regs;
        r.op     = op;
        r.src    = src;
        r.imm    = imm;
        {r.wen, r.word, r.br, r.jmp, r.jr, r.ill, r.ebk} = flags;
        r.lk     = load_none;
        r.mask   = 8'h00;
        r.off    = '0;
        push_row(r);
    endtask

    task mem_row(input bit bub, input inst_t tmpl, input logic [2:0] regs, input imm_sel_e imm,
                 input load_kind_e lk, input store_mask_t mask, input longint off);
        row_t r;
        r.bubble = bub;
        r.tmpl   = tmpl;
        r.regs   = regs;
        r.op     = alu_add;   // address add
        r.src    = src_imm;
        r.imm    = imm;
        {r.word, r.br, r.jmp, r.jr, r.ill, r.ebk} = '0;
        r.wen    = (lk != load_none);
        r.lk     = lk;
        r.mask   = mask;
        r.off    = off;
        push_row(r);
    endtask

    task build_table();
        alu_row(0, 32'h00000033, 3'b111, alu_add, src_reg, imm_i, 7'b1000000);
        alu_row(0, 32'h40000033, 3'b111, alu_sub, src_reg, imm_i, 7'b1000000);
        alu_row(0, 32'h00003033, 3'b111, alu_sltu, src_reg, imm_i, 7'b1000000);
        alu_row(0, 32'h00006033, 3'b111, alu_or, src_reg, imm_i, 7'b1000000);
        alu_row(0, 32'h00007033, 3'b111, alu_and, src_reg, imm_i, 7'b1000000);
        alu_row(0, 32'h02006033, 3'b111, alu_rem, src_reg, imm_i, 7'b1000000);
        alu_row(0, 32'h02007033, 3'b111, alu_remu, src_reg, imm_i, 7'b1000000);
        alu_row(1, 32'h12300013, 3'b110, alu_add, src_imm, imm_i, 7'b1000000);
        alu_row(0, 32'h7FF03013, 3'b110, alu_sltu, src_imm, imm_i, 7'b1000000);
        alu_row(0, 32'hFFF04013, 3'b110, alu_xor, src_imm, imm_i, 7'b1000000);
        alu_row(0, 32'h0F007013, 3'b110, alu_and, src_imm, imm_i, 7'b1000000);
        alu_row(0, 32'h02101013, 3'b110, alu_sll, src_imm, imm_shamt, 7'b1000000);
        alu_row(0, 32'h00505013, 3'b110, alu_srl, src_imm, imm_shamt, 7'b1000000);
        alu_row(0, 32'h43F05013, 3'b110, alu_sra, src_imm, imm_shamt, 7'b1000000);
        alu_row(1, 32'h0000003B, 3'b111, alu_add, src_reg, imm_i, 7'b1100000);
        alu_row(0, 32'h0200003B, 3'b111, alu_mul, src_reg, imm_i, 7'b1100000);
        alu_row(0, 32'h0000103B, 3'b111, alu_sll, src_reg, imm_i, 7'b1100000);
        alu_row(0, 32'h0200403B, 3'b111, alu_div, src_reg, imm_i, 7'b1100000);
        alu_row(0, 32'h0200603B, 3'b111, alu_rem, src_reg, imm_i, 7'b1100000);
        alu_row(0, 32'hFFB0001B, 3'b110, alu_add, src_imm, imm_i, 7'b1100000);
        mem_row(1, 32'hFF802003, 3'b110, imm_i, load_word_signed, 8'h00, -8);
        mem_row(0, 32'h7F003003, 3'b110, imm_i, load_double, 8'h00, 2032);
        mem_row(0, 32'h80004003, 3'b110, imm_i, load_byte_unsigned, 8'h00, -2048);
        mem_row(0, 32'h7E000FA3, 3'b011, imm_s, load_none, 8'h01, 2047);
        mem_row(0, 32'hFE001FA3, 3'b011, imm_s, load_none, 8'h03, -1);
        mem_row(0, 32'h02002023, 3'b011, imm_s, load_none, 8'h0F, 32);
        mem_row(0, 32'hFE003823, 3'b011, imm_s, load_none, 8'hFF, -16);
        alu_row(1, 32'h7FDFF06F, 3'b100, alu_add, src_four_pc, imm_j, 7'b1001000);
        alu_row(0, 32'h01000067, 3'b110, alu_add, src_four_pc, imm_i, 7'b1001100);
        alu_row(0, 32'h12345037, 3'b100, alu_add, src_imm, imm_u, 7'b1000000);
        alu_row(0, 32'hFFFFF017, 3'b100, alu_add, src_imm_pc, imm_u, 7'b1000000);
        alu_row(0, 32'hFE000EE3, 3'b011, alu_cmp_eq, src_reg, imm_b, 7'b0010000);
        alu_row(0, 32'h00001463, 3'b011, alu_cmp_ne, src_reg, imm_b, 7'b0010000);
        alu_row(0, 32'h00005063, 3'b011, alu_cmp_ge, src_reg, imm_b, 7'b0010000);
        alu_row(0, 32'h00006063, 3'b011, alu_cmp_ltu, src_reg, imm_b, 7'b0010000);
        alu_row(1, 32'h0000000B, 3'b111, alu_add, src_reg, imm_i, 7'b0000010);   // custom-0
        alu_row(0, 32'h00000077, 3'b111, alu_add, src_reg, imm_i, 7'b0000010);
        alu_row(0, 32'h00007063, 3'b011, alu_add, src_reg, imm_i, 7'b0000010);   // bgeu
        alu_row(0, 32'h04000033, 3'b111, alu_add, src_reg, imm_i, 7'b0000010);
        alu_row(0, 32'h0000203B, 3'b111, alu_add, src_reg, imm_i, 7'b0000010);
        alu_row(0, 32'h00001003, 3'b110, alu_add, src_reg, imm_i, 7'b0000010);   // lh
        alu_row(0, 32'h00000073, 3'b000, alu_add, src_reg, imm_i, 7'b0000010);   // ecall
        alu_row(1, 32'h00100073, 3'b000, alu_add, src_reg, imm_i, 7'b0000001);
        alu_row(0, 32'h00000033, 3'b111, alu_add, src_reg, imm_i, 7'b1000000);
    endtask

    function automatic inst_t build_word(input int idx);
        inst_t w;
        w = rows[idx].tmpl;
        if (rows[idx].regs[2]) w[rd_lsb +: 5] = rd_f[idx];
        if (rows[idx].regs[1]) w[rs1_lsb +: 5] = rs1_f[idx];
        if (rows[idx].regs[0]) w[rs2_lsb +: 5] = rs2_f[idx];
        return w;
    endfunction

    task compare_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d %s is %0h, expected %0h",
                     $time, checked_row, name, got, exp);
        end
    endtask

    task expect_idle();
        compare_field("dec_valid", dec_valid, 0);
        compare_field("reg_wen", reg_wen, 0);
        compare_field("branch", branch, 0);
        compare_field("jump", jump, 0);
        compare_field("jalr", jalr, 0);
        compare_field("word_op", word_op, 0);
        compare_field("illegal", illegal, 0);
        compare_field("ebreak", ebreak, 0);
        compare_field("store_mask", store_mask, 0);
    endtask

    task verify_row(input int idx);
        row_t r;
        logic live;
        checked_row = idx;
        if (idx < 0) begin
            expect_idle();
        end else begin
            r = rows[idx];
            live = !r.ill && !r.ebk;
            compare_field("dec_valid", dec_valid, 1);
            compare_field("reg_wen", reg_wen, r.wen);
            compare_field("word_op", word_op, r.word);
            compare_field("branch", branch, r.br);
            compare_field("jump", jump, r.jmp);
            compare_field("jalr", jalr, r.jr);
            compare_field("illegal", illegal, r.ill);
            compare_field("ebreak", ebreak, r.ebk);
            compare_field("store_mask", store_mask, r.mask);
            compare_field("load_kind", load_kind, r.lk);
            compare_field("mem_offset", mem_offset, r.off);
            compare_field("rd_addr", rd_addr, (live && r.regs[2]) ? rd_f[idx] : 5'd0);
            compare_field("rs1_addr", rs1_addr, (live && r.regs[1]) ? rs1_f[idx] : 5'd0);
            compare_field("rs2_addr", rs2_addr, (live && r.regs[0]) ? rs2_f[idx] : 5'd0);
            if (live) begin
                compare_field("alu_op", alu_op, r.op);
                compare_field("alu_src", alu_src, r.src);
                if (r.src != src_reg || r.br) begin   // r-type has no immediate
                    compare_field("imm_sel", imm_sel, r.imm);
                end
            end
        end
    endtask

    initial begin
        int i;
        int prev;
        int wait_cycles;
        build_table();
        wait_cycles = 0;
        while (reset && !timed_out) begin
            @(negedge clk);
            expect_idle();   // outputs held low during reset
            wait_cycles++;
            if (wait_cycles > 20) begin
                timed_out = 1'b1;
                $display("Timed out waiting for reset to be released.");
            end
        end
        if (!timed_out) begin
            prev = -1;
            for (i = 0; i < rows.size(); i++) begin
                if (rows[i].bubble) begin
                    @(posedge clk);
                    inst_valid <= 1'b0;
                    inst <= 32'h000000EF;   // jal x1, must be ignored
                    @(negedge clk);
                    verify_row(prev);
                    prev = -1;
                end
                @(posedge clk);
                inst_valid <= 1'b1;
                inst <= build_word(i);
                @(negedge clk);
                verify_row(prev);
                prev = i;
            end
            @(posedge clk);
            inst_valid <= 1'b0;
            inst <= '0;
            @(negedge clk);
            verify_row(prev);
            @(posedge clk);
            @(negedge clk);
            verify_row(-1);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (timed_out || errors != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire
